//--- design/cache_pkg.sv
package cache_pkg;

	// request address and data word
	localparam int ADDR_W = 12;
	localparam int DATA_W = 32;

	// address fields, most significant first
	localparam int TAG_W   = 5;
	localparam int INDEX_W = 3;
	localparam int WORD_W  = 2;
	localparam int BYTE_W  = 2;

	// cache geometry
	localparam int LINES      = 1 << INDEX_W;
	localparam int LINE_WORDS = 1 << WORD_W;

	// word address into backing memory, byte offset dropped
	localparam int MEM_ADDR_W = TAG_W + INDEX_W + WORD_W;

	// hit and miss counters
	localparam int CNT_W = 32;

	// field view of a request address
	typedef struct packed {
		logic [TAG_W-1:0]   tag;
		logic [INDEX_W-1:0] index;
		logic [WORD_W-1:0]  word;
		// byte lanes are not supported, decoded only
		logic [BYTE_W-1:0]  byte_off;
	} cache_addr_s;

	// same bits, flat or split
	typedef union packed {
		logic [ADDR_W-1:0] flat;
		cache_addr_s       f;
	} cache_addr_u;

endpackage

//--- design/cache_store.sv
`timescale 1ns/1ps

module cache_store (
	input  logic                          CLK,
	input  logic                          reset,
	input  logic [cache_pkg::INDEX_W-1:0] index,
	input  logic [cache_pkg::TAG_W-1:0]   tag,
	input  logic [cache_pkg::WORD_W-1:0]  word,
	input  logic                          fill_en,
	input  logic [cache_pkg::WORD_W-1:0]  fill_word,
	input  logic [cache_pkg::DATA_W-1:0]  fill_data,
	input  logic                          alloc_en,
	input  logic                          validate_en,
	input  logic                          word_we,
	input  logic [cache_pkg::DATA_W-1:0]  word_data,
	output logic                          hit,
	output logic [cache_pkg::DATA_W-1:0]  line_word
);
	import cache_pkg::*;

	logic [LINES-1:0]  valid_q;
	logic [TAG_W-1:0]  tag_q  [LINES];
	logic [DATA_W-1:0] data_q [LINES][LINE_WORDS];

	// lookup at the presented index
	assign hit       = valid_q[index] && (tag_q[index] == tag);
	assign line_word = data_q[index][word];

	// alloc clears valid so a partly filled line never hits
	always_ff @(posedge CLK) begin
		if (reset) begin
			valid_q <= '0;
		end else begin
			if (alloc_en) begin
				valid_q[index] <= 1'b0;
			end else if (validate_en) begin
				valid_q[index] <= 1'b1;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (alloc_en) begin
			tag_q[index] <= tag;
		end
	end

	// refill beats and word writes never land in the same cycle
	always_ff @(posedge CLK) begin
		if (fill_en) begin
			data_q[index][fill_word] <= fill_data;
		end
		if (word_we) begin
			data_q[index][word] <= word_data;
		end
	end

endmodule

//--- design/data_memory.sv
`timescale 1ns/1ps

module data_memory #(
	parameter int MEM_LATENCY = 1
) (
	input  logic                             CLK,
	input  logic                             reset,
	input  logic                             mem_req,
	input  logic                             mem_we,
	input  logic [cache_pkg::MEM_ADDR_W-1:0] mem_addr,
	input  logic [cache_pkg::DATA_W-1:0]     mem_wdata,
	output logic [cache_pkg::DATA_W-1:0]     mem_rdata,
	output logic                             mem_ack
);
	import cache_pkg::*;

	localparam int WORDS = 1 << MEM_ADDR_W;
	localparam int LAT_W = $clog2(MEM_LATENCY + 1);

	logic [DATA_W-1:0] mem_q [WORDS];
	logic [LAT_W-1:0]  lat_cnt;
	logic              ack_now;

	// last wait cycle of a request still waiting for its ack
	assign ack_now = mem_req && !mem_ack && (lat_cnt == LAT_W'(MEM_LATENCY - 1));

	always_ff @(posedge CLK) begin
		if (reset) begin
			lat_cnt <= '0;
			mem_ack <= 1'b0;
		end else begin
			mem_ack <= ack_now;
			if (ack_now) begin
				lat_cnt <= '0;
			end else if (mem_req && !mem_ack) begin
				lat_cnt <= lat_cnt + 1'b1;
			end
		end
	end

	// access happens on the edge that raises ack
	always_ff @(posedge CLK) begin
		if (ack_now) begin
			if (mem_we) begin
				mem_q[mem_addr] <= mem_wdata;
			end
			mem_rdata <= mem_q[mem_addr];
		end
	end

endmodule

//--- design/cache_controller.sv
`timescale 1ns/1ps

module cache_controller (
	input  logic                             CLK,
	input  logic                             reset,
	input  logic                             csn,
	input  logic                             wen,
	input  cache_pkg::cache_addr_u           addr,
	input  logic [cache_pkg::DATA_W-1:0]     wdata,
	output logic [cache_pkg::DATA_W-1:0]     rdata,
	output logic                             stall,
	input  logic                             hit,
	input  logic [cache_pkg::DATA_W-1:0]     line_word,
	output logic [cache_pkg::INDEX_W-1:0]    index,
	output logic [cache_pkg::TAG_W-1:0]      tag,
	output logic [cache_pkg::WORD_W-1:0]     word,
	output logic                             fill_en,
	output logic [cache_pkg::WORD_W-1:0]     fill_word,
	output logic [cache_pkg::DATA_W-1:0]     fill_data,
	output logic                             alloc_en,
	output logic                             validate_en,
	output logic                             word_we,
	output logic [cache_pkg::DATA_W-1:0]     word_data,
	input  logic [cache_pkg::DATA_W-1:0]     mem_rdata,
	input  logic                             mem_ack,
	output logic                             mem_req,
	output logic                             mem_we,
	output logic [cache_pkg::MEM_ADDR_W-1:0] mem_addr,
	output logic [cache_pkg::DATA_W-1:0]     mem_wdata,
	output logic [cache_pkg::CNT_W-1:0]      read_hits,
	output logic [cache_pkg::CNT_W-1:0]      read_misses,
	output logic [cache_pkg::CNT_W-1:0]      write_hits,
	output logic [cache_pkg::CNT_W-1:0]      write_misses
);
	import cache_pkg::*;

	localparam logic [2:0] S_IDLE   = 3'd0;
	localparam logic [2:0] S_REFILL = 3'd1;
	localparam logic [2:0] S_FINISH = 3'd2;
	localparam logic [2:0] S_WRITE  = 3'd3;
	localparam logic [2:0] S_WAIT   = 3'd4;

	logic [2:0]        state;
	logic [WORD_W-1:0] beat;
	logic              accept;
	logic              idle;

	// accepted request, stable while stalled
	cache_addr_u       req_addr;
	logic [DATA_W-1:0] req_wdata;
	logic              req_read;

	assign idle   = (state == S_IDLE);
	assign accept = idle && !csn && !stall;

	// lookup on the live request only while idle
	assign index = idle ? addr.f.index : req_addr.f.index;
	assign tag   = idle ? addr.f.tag   : req_addr.f.tag;
	assign word  = idle ? addr.f.word  : req_addr.f.word;

	assign alloc_en    = accept && !hit;
	assign fill_en     = (state == S_REFILL) && mem_req && mem_ack;
	assign fill_word   = beat;
	assign fill_data   = mem_rdata;
	assign validate_en = (state == S_FINISH);

	// write hit goes in at acceptance, write miss once the line is refilled
	assign word_we   = (accept && !wen && hit) || ((state == S_FINISH) && !req_read);
	assign word_data = idle ? wdata : req_wdata;

	always_ff @(posedge CLK) begin
		if (reset) begin
			state   <= S_IDLE;
			stall   <= 1'b0;
			mem_req <= 1'b0;
			mem_we  <= 1'b0;
			rdata   <= '0;
			beat    <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					if (accept) begin
						if (!hit) begin
							stall <= 1'b1;
							beat  <= '0;
							state <= S_REFILL;
						end else if (wen) begin
							rdata <= line_word;
						end else begin
							stall <= 1'b1;
							state <= S_WRITE;
						end
					end
				end
				S_REFILL: begin
					// one beat per request, req low for a cycle in between
					if (mem_req && mem_ack) begin
						mem_req <= 1'b0;
						beat    <= beat + 1'b1;
						if (beat == WORD_W'(LINE_WORDS - 1)) begin
							state <= S_FINISH;
						end
					end else if (!mem_req) begin
						mem_req <= 1'b1;
					end
				end
				S_FINISH: begin
					if (req_read) begin
						rdata <= line_word;
						stall <= 1'b0;
						state <= S_IDLE;
					end else begin
						state <= S_WRITE;
					end
				end
				S_WRITE: begin
					mem_req <= 1'b1;
					mem_we  <= 1'b1;
					state   <= S_WAIT;
				end
				S_WAIT: begin
					if (mem_ack) begin
						mem_req <= 1'b0;
						mem_we  <= 1'b0;
						stall   <= 1'b0;
						state   <= S_IDLE;
					end
				end
				default: begin
					state <= S_IDLE;
				end
			endcase
		end
	end

	// memory address and data only change while mem_req is low
	always_ff @(posedge CLK) begin
		if (accept) begin
			req_addr  <= addr;
			req_wdata <= wdata;
			req_read  <= wen;
		end
		if ((state == S_REFILL) && !mem_req) begin
			mem_addr <= {req_addr.f.tag, req_addr.f.index, beat};
		end
		if (state == S_WRITE) begin
			mem_addr  <= req_addr.flat[ADDR_W-1:BYTE_W];
			mem_wdata <= req_wdata;
		end
	end

	// counted once, at the acceptance edge
	always_ff @(posedge CLK) begin
		if (reset) begin
			read_hits    <= '0;
			read_misses  <= '0;
			write_hits   <= '0;
			write_misses <= '0;
		end else if (accept) begin
			case ({wen, hit})
				2'b11:   read_hits    <= read_hits + 1'b1;
				2'b10:   read_misses  <= read_misses + 1'b1;
				2'b01:   write_hits   <= write_hits + 1'b1;
				default: write_misses <= write_misses + 1'b1;
			endcase
		end
	end

endmodule

//--- design/cache_subsystem.sv
`timescale 1ns/1ps

module cache_subsystem #(
	parameter int MEM_LATENCY = 1
) (
	input  logic                         CLK,
	input  logic                         reset,
	input  logic                         csn,
	input  logic                         wen,
	input  cache_pkg::cache_addr_u       addr,
	input  logic [cache_pkg::DATA_W-1:0] wdata,
	output logic [cache_pkg::DATA_W-1:0] rdata,
	output logic                         stall,
	output logic [cache_pkg::CNT_W-1:0]  read_hits,
	output logic [cache_pkg::CNT_W-1:0]  read_misses,
	output logic [cache_pkg::CNT_W-1:0]  write_hits,
	output logic [cache_pkg::CNT_W-1:0]  write_misses
);
	import cache_pkg::*;

	// controller to store
	logic                hit;
	logic [DATA_W-1:0]   line_word;
	logic [INDEX_W-1:0]  index;
	logic [TAG_W-1:0]    tag;
	logic [WORD_W-1:0]   word;
	logic                fill_en;
	logic [WORD_W-1:0]   fill_word;
	logic [DATA_W-1:0]   fill_data;
	logic                alloc_en;
	logic                validate_en;
	logic                word_we;
	logic [DATA_W-1:0]   word_data;

	// controller to memory
	logic                mem_req;
	logic                mem_we;
	logic [MEM_ADDR_W-1:0] mem_addr;
	logic [DATA_W-1:0]   mem_wdata;
	logic [DATA_W-1:0]   mem_rdata;
	logic                mem_ack;

	cache_controller u_ctrl (
		.CLK          (CLK),
		.reset        (reset),
		.csn          (csn),
		.wen          (wen),
		.addr         (addr),
		.wdata        (wdata),
		.rdata        (rdata),
		.stall        (stall),
		.hit          (hit),
		.line_word    (line_word),
		.index        (index),
		.tag          (tag),
		.word         (word),
		.fill_en      (fill_en),
		.fill_word    (fill_word),
		.fill_data    (fill_data),
		.alloc_en     (alloc_en),
		.validate_en  (validate_en),
		.word_we      (word_we),
		.word_data    (word_data),
		.mem_rdata    (mem_rdata),
		.mem_ack      (mem_ack),
		.mem_req      (mem_req),
		.mem_we       (mem_we),
		.mem_addr     (mem_addr),
		.mem_wdata    (mem_wdata),
		.read_hits    (read_hits),
		.read_misses  (read_misses),
		.write_hits   (write_hits),
		.write_misses (write_misses)
	);

	cache_store u_store (
		.CLK         (CLK),
		.reset       (reset),
		.index       (index),
		.tag         (tag),
		.word        (word),
		.fill_en     (fill_en),
		.fill_word   (fill_word),
		.fill_data   (fill_data),
		.alloc_en    (alloc_en),
		.validate_en (validate_en),
		.word_we     (word_we),
		.word_data   (word_data),
		.hit         (hit),
		.line_word   (line_word)
	);

	data_memory #(
		.MEM_LATENCY (MEM_LATENCY)
	) u_mem (
		.CLK       (CLK),
		.reset     (reset),
		.mem_req   (mem_req),
		.mem_we    (mem_we),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_rdata (mem_rdata),
		.mem_ack   (mem_ack)
	);

endmodule

//--- testbench/cache_checker.sv
`timescale 1ns/1ps

module cache_checker (
	input logic                             CLK,
	input logic                             reset,
	input logic [2:0]                       state,
	input logic                             stall,
	input logic                             mem_req,
	input logic                             mem_ack,
	input logic [cache_pkg::MEM_ADDR_W-1:0] mem_addr,
	input logic [cache_pkg::DATA_W-1:0]     mem_wdata,
	input logic                             fill_en,
	input logic                             validate_en
);
	localparam logic [2:0] IDLE_STATE = 3'd0;

	// refill beats since the last validate
	logic [2:0] fills;

	always_ff @(posedge CLK) begin
		if (reset || validate_en) begin
			fills <= '0;
		end else if (fill_en) begin
			fills <= fills + 1'b1;
		end
	end

	reset_clears: assert property (@(posedge CLK) reset |=> (!stall && !mem_req))
		else $error("stall or mem_req high after reset");

	req_holds: assert property (@(posedge CLK) disable iff (reset)
		(mem_req && !mem_ack) |=> (mem_req && $stable(mem_addr) && $stable(mem_wdata)))
		else $error("memory request changed before its acknowledge");

	idle_quiet: assert property (@(posedge CLK) disable iff (reset)
		(state == IDLE_STATE) |-> !mem_req)
		else $error("mem_req high in idle state");

	full_line: assert property (@(posedge CLK) disable iff (reset)
		validate_en |-> (fills == 3'd4))
		else $error("line validated before four fills");

endmodule

//--- testbench/cache_tb.sv
`timescale 1ns/1ps

module cache_tb;
	import cache_pkg::*;

	localparam int MEM_LATENCY  = 2;
	localparam int REGION_WORDS = 64;
	localparam int RANDOM_OPS   = 200;
	// all requests of all tests
	localparam int NUM_REQUESTS = 2 + 10 + 8 + 5 + REGION_WORDS + RANDOM_OPS + 3;
	localparam int WATCHDOG_CYCLES = NUM_REQUESTS * (4 * MEM_LATENCY + 12) + 50;

	logic              CLK;
	logic              reset;
	logic              csn;
	logic              wen;
	cache_addr_u       addr;
	logic [DATA_W-1:0] wdata;
	logic [DATA_W-1:0] rdata;
	logic              stall;
	logic [CNT_W-1:0]  read_hits;
	logic [CNT_W-1:0]  read_misses;
	logic [CNT_W-1:0]  write_hits;
	logic [CNT_W-1:0]  write_misses;

	// reference model
	logic [DATA_W-1:0] shadow_mem [1 << MEM_ADDR_W];
	logic [TAG_W-1:0]  model_tag [LINES];
	logic [LINES-1:0]  model_valid;
	logic [CNT_W-1:0]  model_rh, model_rm, model_wh, model_wm;

	// snapshot of one finished request for the compare process
	string             cmp_name;
	logic              cmp_is_read;
	logic              cmp_hit;
	logic              cmp_stalled;
	logic [DATA_W-1:0] cmp_word;
	logic [CNT_W-1:0]  cmp_rh, cmp_rm, cmp_wh, cmp_wm;
	event              access_done;

	int seed;

	cache_subsystem #(
		.MEM_LATENCY (MEM_LATENCY)
	) u_dut (
		.CLK          (CLK),
		.reset        (reset),
		.csn          (csn),
		.wen          (wen),
		.addr         (addr),
		.wdata        (wdata),
		.rdata        (rdata),
		.stall        (stall),
		.read_hits    (read_hits),
		.read_misses  (read_misses),
		.write_hits   (write_hits),
		.write_misses (write_misses)
	);

	bind cache_controller cache_checker u_checker (
		.CLK         (CLK),
		.reset       (reset),
		.state       (state),
		.stall       (stall),
		.mem_req     (mem_req),
		.mem_ack     (mem_ack),
		.mem_addr    (mem_addr),
		.mem_wdata   (mem_wdata),
		.fill_en     (fill_en),
		.validate_en (validate_en)
	);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	task automatic check_word(input string name, input logic [DATA_W-1:0] expected,
			input logic [DATA_W-1:0] actual);
		if (actual !== expected) begin
			$display("** Error %s: expected %h, actual %h", name, expected, actual);
			$display("=== FAIL ===");
			$fatal(1, "word mismatch");
		end
	endtask

	task automatic check_count(input string name, input logic [CNT_W-1:0] expected,
			input logic [CNT_W-1:0] actual);
		if (actual !== expected) begin
			$display("** Error %s: expected %0d, actual %0d", name, expected, actual);
			$display("=== FAIL ===");
			$fatal(1, "counter mismatch");
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("** Error %s: expected %b, actual %b", name, expected, actual);
			$display("=== FAIL ===");
			$fatal(1, "flag mismatch");
		end
	endtask

	function automatic logic [ADDR_W-1:0] addr_of(input int tag, input int index, input int word);
		return {TAG_W'(tag), INDEX_W'(index), WORD_W'(word), BYTE_W'(0)};
	endfunction

	// expected word comes from the shadow memory and hit from the model tags
	function automatic logic [DATA_W-1:0] ref_lookup(input cache_addr_u a, output logic is_hit);
		is_hit = model_valid[a.f.index] && (model_tag[a.f.index] == a.f.tag);
		return shadow_mem[{a.f.tag, a.f.index, a.f.word}];
	endfunction

	task automatic model_update(input cache_addr_u a, input logic is_read, input logic is_hit,
			input logic [DATA_W-1:0] data);
		// reads and writes both allocate on a miss
		if (!is_hit) begin
			model_valid[a.f.index] = 1'b1;
			model_tag[a.f.index]   = a.f.tag;
		end
		if (is_read) begin
			if (is_hit) model_rh++;
			else model_rm++;
		end else begin
			if (is_hit) model_wh++;
			else model_wm++;
			shadow_mem[{a.f.tag, a.f.index, a.f.word}] = data;
		end
	endtask

	// called at a falling edge with the cache idle
	task automatic issue_request(input string name, input logic is_read,
			input logic [ADDR_W-1:0] byte_addr, input logic [DATA_W-1:0] data);
		cache_addr_u       a;
		logic              is_hit;
		logic [DATA_W-1:0] expected;
		int                waited;
		a.flat   = byte_addr;
		expected = ref_lookup(a, is_hit);
		model_update(a, is_read, is_hit, data);
		csn   = 1'b0;
		wen   = is_read;
		addr  = a;
		wdata = data;
		@(posedge CLK);
		@(negedge CLK);
		waited = 0;
		while (stall) begin
			waited++;
			@(negedge CLK);
		end
		csn         = 1'b1;
		cmp_name    = name;
		cmp_is_read = is_read;
		cmp_hit     = is_hit;
		cmp_stalled = (waited != 0);
		cmp_word    = expected;
		cmp_rh      = model_rh;
		cmp_rm      = model_rm;
		cmp_wh      = model_wh;
		cmp_wm      = model_wm;
		-> access_done;
	endtask

	task automatic apply_reset();
		reset = 1'b1;
		csn   = 1'b1;
		repeat (2) @(posedge CLK);
		@(negedge CLK);
		reset       = 1'b0;
		model_valid = '0;
		model_rh    = '0;
		model_rm    = '0;
		model_wh    = '0;
		model_wm    = '0;
	endtask

	task automatic check_reset_state(input string name);
		check_flag({name, " stall"}, 1'b0, stall);
		check_word({name, " rdata"}, '0, rdata);
		check_count({name, " read_hits"}, '0, read_hits);
		check_count({name, " read_misses"}, '0, read_misses);
		check_count({name, " write_hits"}, '0, write_hits);
		check_count({name, " write_misses"}, '0, write_misses);
	endtask

	// compares each finished request against the model
	initial begin
		forever begin
			@(access_done);
			if (cmp_is_read) begin
				check_word({cmp_name, " rdata"}, cmp_word, rdata);
			end
			// only a read hit completes without stall
			check_flag({cmp_name, " stall"}, !(cmp_is_read && cmp_hit), cmp_stalled);
			check_count({cmp_name, " read_hits"}, cmp_rh, read_hits);
			check_count({cmp_name, " read_misses"}, cmp_rm, read_misses);
			check_count({cmp_name, " write_hits"}, cmp_wh, write_hits);
			check_count({cmp_name, " write_misses"}, cmp_wm, write_misses);
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge CLK);
		$display("timeout, requests did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("=== FAIL ===");
		$fatal(1, "watchdog expired");
	end

	initial begin
		logic [31:0]       r;
		logic [DATA_W-1:0] data;
		reset = 1'b1;
		csn   = 1'b1;
		wen   = 1'b1;
		addr  = '0;
		wdata = '0;
		seed  = 73493;
		apply_reset();
		check_reset_state("initial reset");

		issue_request("write miss", 1'b0, addr_of(8, 0, 0), 32'hCAFE_0001);
		issue_request("read hit after write", 1'b1, addr_of(8, 0, 0), '0);

		issue_request("refill setup", 1'b0, addr_of(10, 1, 2), 32'h1111_2222);
		for (int w = 0; w < LINE_WORDS; w++) begin
			issue_request($sformatf("refill write %0d", w), 1'b0, addr_of(9, 1, w),
				32'hBEEF_0000 + DATA_W'(w));
		end
		issue_request("refill evict", 1'b1, addr_of(10, 1, 2), '0);
		for (int w = 0; w < LINE_WORDS; w++) begin
			issue_request($sformatf("refill read %0d", w), 1'b1, addr_of(9, 1, w), '0);
		end

		issue_request("conflict write a", 1'b0, addr_of(11, 2, 1), 32'hAAAA_0B0B);
		issue_request("conflict write b", 1'b0, addr_of(12, 2, 1), 32'hBBBB_0C0C);
		for (int i = 0; i < 6; i++) begin
			issue_request($sformatf("conflict read %0d", i), 1'b1,
				addr_of((i % 2 == 0) ? 11 : 12, 2, 1), '0);
		end

		issue_request("write hit miss", 1'b0, addr_of(13, 3, 1), 32'h0000_AAAA);
		issue_request("write hit", 1'b0, addr_of(13, 3, 1), 32'h0000_BBBB);
		issue_request("write hit read", 1'b1, addr_of(13, 3, 1), '0);
		issue_request("write hit evict", 1'b0, addr_of(14, 3, 0), 32'h0000_CCCC);
		issue_request("write hit refill", 1'b1, addr_of(13, 3, 1), '0);

		// every word of the random region is written before it is read
		for (int i = 0; i < REGION_WORDS; i++) begin
			issue_request("preload", 1'b0, {MEM_ADDR_W'(i), BYTE_W'(0)},
				32'h5AA5_0000 ^ (DATA_W'(i) * 32'h0001_0101));
		end
		for (int i = 0; i < RANDOM_OPS; i++) begin
			r    = $random(seed);
			data = $random(seed);
			issue_request($sformatf("random op %0d", i), r[6], {4'b0000, r[5:0], r[8:7]}, data);
		end

		// line 0 is resident going into reset
		issue_request("read before reset", 1'b1, addr_of(8, 0, 0), '0);
		apply_reset();
		check_reset_state("second reset");
		// backing memory keeps its contents across reset
		issue_request("first read after reset", 1'b1, addr_of(8, 0, 0), '0);
		issue_request("second read after reset", 1'b1, addr_of(8, 0, 0), '0);

		repeat (2) @(negedge CLK);
		$display("=== PASS ===");
		$finish;
	end

endmodule

//--- project.f
design/cache_pkg.sv
design/cache_store.sv
design/data_memory.sv
design/cache_controller.sv
design/cache_subsystem.sv
testbench/cache_checker.sv
testbench/cache_tb.sv

//--- run.sh
#!/bin/sh
# compile with Verilator, run the testbench, decide from the log
rm -f sim.log
verilator --binary --timing --assert -f project.f --top-module cache_tb -o cache_sim \
	&& ./obj_dir/cache_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "=== FAIL ===" sim.log && { echo "simulation failed"; exit 1; }
grep -q "=== PASS ===" sim.log || { echo "simulation did not pass"; exit 1; }
echo "simulation passed"
